/* source/bridge_consts.svh */
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////
`define BR_PADDR_W    32
`define BR_DATA_W     32
`define BR_MASK_W     4
`define BR_EPA_W      18
`define BR_X_W        6
`define BR_Y_W        4

// transaction slots, id width must cover the count
`define BR_SLOTS      4
`define BR_ID_W       2

//////////////////////////////////////////////////
// address map
//////////////////////////////////////////////////
// top two address bits pick the target
`define BR_TGT_TILE   2'b11
`define BR_TGT_VCACHE 2'b10

// field positions inside the command address
`define BR_EPA_LSB    2
`define BR_X_LSB      20
`define BR_POD_LSB    26

`endif

/* source/bridge_pkg.sv */
`include "bridge_consts.svh"

package bridge_pkg;

  // host command kinds
  typedef enum logic [1:0]
  {
    e_cmd_read   = 2'd0,
    e_cmd_write  = 2'd1,
    e_cmd_atomic = 2'd2
  } cmd_type_e;

  // atomic subops on the host side
  typedef enum logic [1:0]
  {
    e_amo_add  = 2'd0,
    e_amo_or   = 2'd1,
    e_amo_swap = 2'd2
  } amo_op_e;

  typedef enum logic [1:0]
  {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2
  } msg_size_e;

  // network packet ops
  typedef enum logic [2:0]
  {
    e_remote_load    = 3'd0,
    e_remote_store   = 3'd1,
    e_remote_amoadd  = 3'd2,
    e_remote_amoor   = 3'd3,
    e_remote_amoswap = 3'd4
  } mc_op_e;

  typedef struct packed
  {
    logic       is_byte;
    logic       is_hex;
    logic [1:0] part_sel;
  } load_info_s;

  // what a slot keeps to rebuild the response
  typedef struct packed
  {
    cmd_type_e               cmd_type;
    msg_size_e               size;
    logic [`BR_PADDR_W-1:0]  addr;
  } slot_hdr_s;

endpackage

/* source/slot_bus_if.sv */
`timescale 1ns/10ps
`include "bridge_consts.svh"

interface slot_bus_if
  import bridge_pkg::*;
();

  // allocation from the translator
  logic                                   alloc_v;
  logic [`BR_ID_W-1:0]                    alloc_id;
  slot_hdr_s                              alloc_hdr;

  // per slot state, one entry per slot
  logic [`BR_SLOTS-1:0]                   busy;
  logic [`BR_SLOTS-1:0]                   done;
  slot_hdr_s [`BR_SLOTS-1:0]              hdr;
  logic [`BR_SLOTS-1:0][`BR_DATA_W-1:0]   data;

  // returns and frees from the drain
  logic                                   ret_v;
  logic [`BR_ID_W-1:0]                    ret_id;
  logic [`BR_DATA_W-1:0]                  ret_data;
  logic                                   free_v;
  logic [`BR_ID_W-1:0]                    free_id;

  modport feed (output alloc_v, alloc_id, alloc_hdr, input busy);

  modport slot (input alloc_v, alloc_id, alloc_hdr,
                input ret_v, ret_id, ret_data,
                input free_v, free_id,
                output busy, done, hdr, data);

  modport drain (output ret_v, ret_id, ret_data, free_v, free_id,
                 input done, hdr, data);

endinterface

/* source/cmd_translator.sv */
`timescale 1ns/10ps
`include "bridge_consts.svh"

module cmd_translator
  import bridge_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  input  logic                    cmd_v_i,
  output logic                    cmd_ready_o,
  input  cmd_type_e               cmd_type_i,
  input  amo_op_e                 cmd_amo_i,
  input  msg_size_e               cmd_size_i,
  input  logic [`BR_PADDR_W-1:0]  cmd_addr_i,
  input  logic [`BR_DATA_W-1:0]   cmd_data_i,

  output logic                    req_v_o,
  input  logic                    req_ready_i,
  output logic [`BR_X_W-1:0]      req_x_o,
  output logic [`BR_Y_W-1:0]      req_y_o,
  output logic [`BR_EPA_W-1:0]    req_addr_o,
  output mc_op_e                  req_op_o,
  output logic [`BR_DATA_W-1:0]   req_data_o,
  output logic [`BR_MASK_W-1:0]   req_mask_o,
  output load_info_s              req_load_info_o,
  output logic [`BR_ID_W-1:0]     req_reg_id_o,

  input  logic [`BR_X_W-1:0]      my_x_i,
  input  logic [`BR_Y_W-1:0]      my_y_i,

  slot_bus_if.feed                bus
);

  localparam int POD_W = `BR_Y_W - 1;
  localparam logic [`BR_ID_W-1:0] LAST_ID = `BR_ID_W'(`BR_SLOTS - 1);

  logic [`BR_ID_W-1:0]    alloc_ptr_q;
  logic                   tail_free;
  logic                   cmd_take;
  logic [1:0]             tgt;
  logic [1:0]             low_bits;
  logic [POD_W-1:0]       vc_pod;
  logic [`BR_MASK_W-1:0]  store_mask;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////
  assign tgt      = cmd_addr_i[`BR_PADDR_W-1 -: 2];
  assign low_bits = cmd_addr_i[1:0];

  // vcache rows sit on even pods
  assign vc_pod = {cmd_addr_i[`BR_POD_LSB +: POD_W-1], 1'b0};

  always_comb
    begin
      if (tgt == `BR_TGT_TILE)
        begin
          req_addr_o = cmd_addr_i[`BR_EPA_LSB +: `BR_EPA_W];
          req_x_o    = cmd_addr_i[`BR_X_LSB +: `BR_X_W];
          req_y_o    = cmd_addr_i[`BR_X_LSB + `BR_X_W +: `BR_Y_W];
        end
      else if (tgt == `BR_TGT_VCACHE)
        begin
          req_addr_o = cmd_addr_i[`BR_EPA_LSB +: `BR_EPA_W];
          req_x_o    = cmd_addr_i[`BR_X_LSB +: `BR_X_W];
          req_y_o    = {vc_pod, (vc_pod == '0)};
        end
      else
        begin
          // host link sits one row above
          req_addr_o = cmd_addr_i[`BR_EPA_W-1:0];
          req_x_o    = '0;
          req_y_o    = my_y_i - 1'b1;
        end
    end

  //////////////////////////////////////////////////
  // packet build
  //////////////////////////////////////////////////
  always_comb
    begin
      case (cmd_size_i)
        e_size_1: store_mask = `BR_MASK_W'('h1) << low_bits;
        e_size_2: store_mask = `BR_MASK_W'('h3) << low_bits;
        default:  store_mask = `BR_MASK_W'('hf) << low_bits;
      endcase
    end

  always_comb
    begin
      req_op_o        = e_remote_load;
      req_data_o      = '0;
      req_mask_o      = '0;
      req_load_info_o = '0;
      case (cmd_type_i)
        e_cmd_write:
          begin
            req_op_o   = e_remote_store;
            req_data_o = cmd_data_i;
            req_mask_o = store_mask;
          end
        e_cmd_atomic:
          begin
            req_data_o = cmd_data_i;
            req_mask_o = '1;
            case (cmd_amo_i)
              e_amo_add: req_op_o = e_remote_amoadd;
              e_amo_or:  req_op_o = e_remote_amoor;
              default:   req_op_o = e_remote_amoswap;
            endcase
          end
        default:
          begin
            req_load_info_o.is_byte  = (cmd_size_i == e_size_1);
            req_load_info_o.is_hex   = (cmd_size_i == e_size_2);
            req_load_info_o.part_sel = low_bits;
          end
      endcase
    end

  //////////////////////////////////////////////////
  // slot allocation
  //////////////////////////////////////////////////
  assign tail_free    = ~bus.busy[alloc_ptr_q];
  assign cmd_ready_o  = tail_free & req_ready_i;
  assign req_v_o      = cmd_v_i & tail_free;
  assign cmd_take     = cmd_v_i & cmd_ready_o;
  assign req_reg_id_o = alloc_ptr_q;

  assign bus.alloc_v   = cmd_take;
  assign bus.alloc_id  = alloc_ptr_q;
  assign bus.alloc_hdr = '{cmd_type: cmd_type_i, size: cmd_size_i, addr: cmd_addr_i};

  always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        begin
          alloc_ptr_q <= '0;
        end
      else if (cmd_take)
        begin
          alloc_ptr_q <= (alloc_ptr_q == LAST_ID) ? '0 : alloc_ptr_q + 1'b1;
        end
    end

  // no incoming request path here, a packet aimed at this node would never drain
  a_not_self: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_take |-> !((req_x_o == my_x_i) && (req_y_o == my_y_i)));

endmodule

/* source/txn_slot.sv */
`timescale 1ns/10ps
`include "bridge_consts.svh"

module txn_slot
  import bridge_pkg::*;
#(
  parameter int SLOT_IDX = 0
)
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  slot_bus_if.slot  bus
);

  localparam logic [`BR_ID_W-1:0] MY_ID = `BR_ID_W'(SLOT_IDX);

  logic                   busy_q;
  logic                   done_q;
  slot_hdr_s              hdr_q;
  logic [`BR_DATA_W-1:0]  data_q;
  logic                   alloc_hit;
  logic                   ret_hit;
  logic                   free_hit;

  assign alloc_hit = bus.alloc_v & (bus.alloc_id == MY_ID);
  assign ret_hit   = bus.ret_v & (bus.ret_id == MY_ID);
  assign free_hit  = bus.free_v & (bus.free_id == MY_ID);

  // busy from allocation to free, done from return to free
  always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        begin
          busy_q <= 1'b0;
          done_q <= 1'b0;
        end
      else
        begin
          if (alloc_hit)
            busy_q <= 1'b1;
          else if (free_hit)
            busy_q <= 1'b0;
          if (ret_hit)
            done_q <= 1'b1;
          else if (free_hit)
            done_q <= 1'b0;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (alloc_hit)
        hdr_q <= bus.alloc_hdr;
      if (ret_hit)
        data_q <= bus.ret_data;
    end

  assign bus.busy[SLOT_IDX] = busy_q;
  assign bus.done[SLOT_IDX] = done_q;
  assign bus.hdr[SLOT_IDX]  = hdr_q;
  assign bus.data[SLOT_IDX] = data_q;

  a_alloc_free: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alloc_hit |-> !busy_q);

  // One return per request, and only while it is outstanding.
  a_ret_live: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ret_hit |-> busy_q && !done_q);

endmodule

/* source/resp_drain.sv */
`timescale 1ns/10ps
`include "bridge_consts.svh"

module resp_drain
  import bridge_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  input  logic                    ret_v_i,
  input  logic [`BR_ID_W-1:0]     ret_reg_id_i,
  input  logic [`BR_DATA_W-1:0]   ret_data_i,

  output logic                    resp_v_o,
  input  logic                    resp_ready_i,
  output cmd_type_e               resp_type_o,
  output msg_size_e               resp_size_o,
  output logic [`BR_PADDR_W-1:0]  resp_addr_o,
  output logic [`BR_DATA_W-1:0]   resp_data_o,

  slot_bus_if.drain               bus
);

  localparam logic [`BR_ID_W-1:0] LAST_ID = `BR_ID_W'(`BR_SLOTS - 1);

  logic [`BR_ID_W-1:0]    drain_ptr_q;
  logic                   resp_take;
  slot_hdr_s              head_hdr;
  logic [`BR_DATA_W-1:0]  head_data;

  // returns are never stalled, the slot was reserved at allocation
  assign bus.ret_v    = ret_v_i;
  assign bus.ret_id   = ret_reg_id_i;
  assign bus.ret_data = ret_data_i;

  //////////////////////////////////////////////////
  // in order drain
  //////////////////////////////////////////////////
  assign head_hdr  = bus.hdr[drain_ptr_q];
  assign head_data = bus.data[drain_ptr_q];
  assign resp_v_o  = bus.done[drain_ptr_q];
  assign resp_take = resp_v_o & resp_ready_i;

  assign bus.free_v  = resp_take;
  assign bus.free_id = drain_ptr_q;

  always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
        begin
          drain_ptr_q <= '0;
        end
      else if (resp_take)
        begin
          drain_ptr_q <= (drain_ptr_q == LAST_ID) ? '0 : drain_ptr_q + 1'b1;
        end
    end

  assign resp_type_o = head_hdr.cmd_type;
  assign resp_size_o = head_hdr.size;
  assign resp_addr_o = head_hdr.addr;

  // narrow loads come back in the low lanes
  always_comb
    begin
      case (head_hdr.cmd_type)
        e_cmd_read:
          begin
            case (head_hdr.size)
              e_size_1: resp_data_o = {(`BR_DATA_W/8){head_data[7:0]}};
              e_size_2: resp_data_o = {(`BR_DATA_W/16){head_data[15:0]}};
              default:  resp_data_o = head_data;
            endcase
          end
        e_cmd_write: resp_data_o = '0;
        default:     resp_data_o = head_data;
      endcase
    end

  a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_type_o) && $stable(resp_size_o)
      && $stable(resp_addr_o) && $stable(resp_data_o));

endmodule

/* source/mc_bridge_top.sv */
`timescale 1ns/10ps
`include "bridge_consts.svh"

module mc_bridge_top
  import bridge_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // host command port
  input  logic                    cmd_v_i,
  output logic                    cmd_ready_o,
  input  cmd_type_e               cmd_type_i,
  input  amo_op_e                 cmd_amo_i,
  input  msg_size_e               cmd_size_i,
  input  logic [`BR_PADDR_W-1:0]  cmd_addr_i,
  input  logic [`BR_DATA_W-1:0]   cmd_data_i,

  // network request
  output logic                    req_v_o,
  input  logic                    req_ready_i,
  output logic [`BR_X_W-1:0]      req_x_o,
  output logic [`BR_Y_W-1:0]      req_y_o,
  output logic [`BR_EPA_W-1:0]    req_addr_o,
  output mc_op_e                  req_op_o,
  output logic [`BR_DATA_W-1:0]   req_data_o,
  output logic [`BR_MASK_W-1:0]   req_mask_o,
  output load_info_s              req_load_info_o,
  output logic [`BR_ID_W-1:0]     req_reg_id_o,

  // network return, always accepted
  input  logic                    ret_v_i,
  input  logic [`BR_ID_W-1:0]     ret_reg_id_i,
  input  logic [`BR_DATA_W-1:0]   ret_data_i,

  // host response port
  output logic                    resp_v_o,
  input  logic                    resp_ready_i,
  output cmd_type_e               resp_type_o,
  output msg_size_e               resp_size_o,
  output logic [`BR_PADDR_W-1:0]  resp_addr_o,
  output logic [`BR_DATA_W-1:0]   resp_data_o,

  input  logic [`BR_X_W-1:0]      my_x_i,
  input  logic [`BR_Y_W-1:0]      my_y_i
);

  slot_bus_if bus ();

  cmd_translator u_translator
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cmd_v_i         (cmd_v_i),
    .cmd_ready_o     (cmd_ready_o),
    .cmd_type_i      (cmd_type_i),
    .cmd_amo_i       (cmd_amo_i),
    .cmd_size_i      (cmd_size_i),
    .cmd_addr_i      (cmd_addr_i),
    .cmd_data_i      (cmd_data_i),
    .req_v_o         (req_v_o),
    .req_ready_i     (req_ready_i),
    .req_x_o         (req_x_o),
    .req_y_o         (req_y_o),
    .req_addr_o      (req_addr_o),
    .req_op_o        (req_op_o),
    .req_data_o      (req_data_o),
    .req_mask_o      (req_mask_o),
    .req_load_info_o (req_load_info_o),
    .req_reg_id_o    (req_reg_id_o),
    .my_x_i          (my_x_i),
    .my_y_i          (my_y_i),
    .bus             (bus)
  );

  //////////////////////////////////////////////////
  // transaction slots, one per reg id
  //////////////////////////////////////////////////
  for (genvar i = 0; i < `BR_SLOTS; i++)
    begin : g_slot
      txn_slot #(.SLOT_IDX(i)) u_slot
      (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (bus)
      );
    end

  resp_drain u_drain
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ret_v_i      (ret_v_i),
    .ret_reg_id_i (ret_reg_id_i),
    .ret_data_i   (ret_data_i),
    .resp_v_o     (resp_v_o),
    .resp_ready_i (resp_ready_i),
    .resp_type_o  (resp_type_o),
    .resp_size_o  (resp_size_o),
    .resp_addr_o  (resp_addr_o),
    .resp_data_o  (resp_data_o),
    .bus          (bus)
  );

endmodule

/* verif/mc_net_model.sv */
`timescale 1ns/10ps
`include "bridge_consts.svh"

module mc_net_model
  import bridge_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_v_i,
  input  logic                    req_ready_i,
  input  logic [`BR_EPA_W-1:0]    req_addr_i,
  input  mc_op_e                  req_op_i,
  input  logic [`BR_ID_W-1:0]     req_reg_id_i,
  output logic                    ret_v_o,
  output logic [`BR_ID_W-1:0]     ret_reg_id_o,
  output logic [`BR_DATA_W-1:0]   ret_data_o
);

  integer                 seed;
  logic                   sent;
  logic                   pend_v    [`BR_SLOTS];
  int                     pend_wait [`BR_SLOTS];
  logic [`BR_DATA_W-1:0]  pend_data [`BR_SLOTS];

  // memory contents as seen through the network address
  function automatic logic [`BR_DATA_W-1:0] load_pattern(logic [`BR_EPA_W-1:0] epa);
    return {~epa[13:0], epa};
  endfunction

  initial
    begin
      seed         = 38;
      ret_v_o      = 1'b0;
      ret_reg_id_o = '0;
      ret_data_o   = '0;
      for (int i = 0; i < `BR_SLOTS; i++)
        pend_v[i] = 1'b0;
    end

  // requests are taken on the rising edge, returns leave on the falling edge
  always @(posedge clk_i or negedge clk_i)
    begin
      if (clk_i)
        begin
          if (rst_n_i && req_v_i && req_ready_i)
            begin
              pend_v[req_reg_id_i]    = 1'b1;
              pend_wait[req_reg_id_i] = 1 + ($random(seed) & 7);
              pend_data[req_reg_id_i] = (req_op_i == e_remote_store) ? '0
                                        : load_pattern(req_addr_i);
            end
        end
      else
        begin
          sent    = 1'b0;
          ret_v_o = 1'b0;
          for (int i = 0; i < `BR_SLOTS; i++)
            if (!rst_n_i)
              pend_v[i] = 1'b0;
            else if (pend_v[i] && pend_wait[i] > 0)
              pend_wait[i] = pend_wait[i] - 1;
          // one return per cycle, lowest id first
          for (int i = 0; i < `BR_SLOTS; i++)
            if (!sent && pend_v[i] && pend_wait[i] == 0)
              begin
                sent         = 1'b1;
                ret_v_o      = 1'b1;
                ret_reg_id_o = `BR_ID_W'(i);
                ret_data_o   = pend_data[i];
                pend_v[i]    = 1'b0;
              end
        end
    end

endmodule

/* verif/tb_mc_bridge.sv */
`timescale 1ns/10ps
`include "bridge_consts.svh"

module tb_mc_bridge
  import bridge_pkg::*;
();

  localparam int WAIT_LIMIT = 200;

  logic clk, rst_n;
  logic cmd_v, cmd_ready, req_v, req_ready, ret_v, resp_v, resp_ready;
  cmd_type_e cmd_type, resp_type;
  amo_op_e cmd_amo;
  msg_size_e cmd_size, resp_size;
  logic [`BR_PADDR_W-1:0] cmd_addr, resp_addr;
  logic [`BR_DATA_W-1:0] cmd_data, req_data, ret_data, resp_data;
  logic [`BR_X_W-1:0] req_x, my_x;
  logic [`BR_Y_W-1:0] req_y, my_y;
  logic [`BR_EPA_W-1:0] req_addr;
  mc_op_e req_op;
  logic [`BR_MASK_W-1:0] req_mask;
  load_info_s req_info;
  logic [`BR_ID_W-1:0] req_reg_id, ret_reg_id;

  // expected request fields
  logic [1:0] tgt;
  logic [`BR_EPA_W-1:0] exp_epa;
  logic [`BR_X_W-1:0] exp_x;
  logic [`BR_Y_W-1:0] exp_y;
  mc_op_e exp_op;
  logic [`BR_MASK_W-1:0] exp_mask;
  load_info_s exp_info;

  // responses still owed in command order
  cmd_type_e exp_type [64];
  msg_size_e exp_size [64];
  logic [`BR_PADDR_W-1:0] exp_addr [64];
  logic [`BR_DATA_W-1:0] exp_data [64];
  logic [5:0] wr_idx, rd_idx, in_flight;
  logic cmd_take, resp_take;

  mc_bridge_top uut
  (
    .clk_i (clk), .rst_n_i (rst_n),
    .cmd_v_i (cmd_v), .cmd_ready_o (cmd_ready), .cmd_type_i (cmd_type),
    .cmd_amo_i (cmd_amo), .cmd_size_i (cmd_size), .cmd_addr_i (cmd_addr),
    .cmd_data_i (cmd_data),
    .req_v_o (req_v), .req_ready_i (req_ready), .req_x_o (req_x), .req_y_o (req_y),
    .req_addr_o (req_addr), .req_op_o (req_op), .req_data_o (req_data),
    .req_mask_o (req_mask), .req_load_info_o (req_info), .req_reg_id_o (req_reg_id),
    .ret_v_i (ret_v), .ret_reg_id_i (ret_reg_id), .ret_data_i (ret_data),
    .resp_v_o (resp_v), .resp_ready_i (resp_ready), .resp_type_o (resp_type),
    .resp_size_o (resp_size), .resp_addr_o (resp_addr), .resp_data_o (resp_data),
    .my_x_i (my_x), .my_y_i (my_y)
  );

  mc_net_model u_net
  (
    .clk_i (clk), .rst_n_i (rst_n), .req_v_i (req_v), .req_ready_i (req_ready),
    .req_addr_i (req_addr), .req_op_i (req_op), .req_reg_id_i (req_reg_id),
    .ret_v_o (ret_v), .ret_reg_id_o (ret_reg_id), .ret_data_o (ret_data)
  );

  initial
    clk = 1'b0;
  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic logic [`BR_DATA_W-1:0] load_pattern(logic [`BR_EPA_W-1:0] epa);
    return {~epa[13:0], epa};
  endfunction

  function automatic logic [`BR_DATA_W-1:0] response_word(cmd_type_e t, msg_size_e s,
                                                          logic [`BR_EPA_W-1:0] epa);
    logic [`BR_DATA_W-1:0] word;
    word = load_pattern(epa);
    if (t == e_cmd_write)
      return '0;
    if (t == e_cmd_read && s == e_size_1)
      return {4{word[7:0]}};
    if (t == e_cmd_read && s == e_size_2)
      return {2{word[15:0]}};
    return word;
  endfunction

  always_comb
    begin
      tgt     = cmd_addr[31:30];
      exp_epa = cmd_addr[19:2];
      exp_x   = cmd_addr[25:20];
      exp_y   = cmd_addr[29:26];
      if (tgt == `BR_TGT_VCACHE)
        exp_y = {cmd_addr[27:26], 1'b0, cmd_addr[27:26] == 2'b00};
      else if (tgt != `BR_TGT_TILE)
        begin
          exp_epa = cmd_addr[17:0];
          exp_x   = '0;
          exp_y   = my_y - 4'd1;
        end
      exp_op   = e_remote_load;
      exp_mask = 4'hf;
      if (cmd_type == e_cmd_write)
        begin
          exp_op = e_remote_store;
          if (cmd_size == e_size_1)
            exp_mask = 4'h1 << cmd_addr[1:0];
          else if (cmd_size == e_size_2)
            exp_mask = 4'h3 << cmd_addr[1:0];
          else
            exp_mask = 4'hf << cmd_addr[1:0];
        end
      else if (cmd_type == e_cmd_atomic)
        exp_op = (cmd_amo == e_amo_add) ? e_remote_amoadd
               : (cmd_amo == e_amo_or) ? e_remote_amoor : e_remote_amoswap;
      exp_info.is_byte  = (cmd_size == e_size_1);
      exp_info.is_hex   = (cmd_size == e_size_2);
      exp_info.part_sel = cmd_addr[1:0];
    end

  assign cmd_take  = cmd_v && cmd_ready;
  assign resp_take = resp_v && resp_ready;
  assign in_flight = wr_idx - rd_idx;

  always @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
        begin
          wr_idx <= '0;
          rd_idx <= '0;
        end
      else
        begin
          if (cmd_take)
            begin
              exp_type[wr_idx] <= cmd_type;
              exp_size[wr_idx] <= cmd_size;
              exp_addr[wr_idx] <= cmd_addr;
              exp_data[wr_idx] <= response_word(cmd_type, cmd_size, exp_epa);
              wr_idx           <= wr_idx + 6'd1;
            end
          if (resp_take)
            rd_idx <= rd_idx + 6'd1;
        end
    end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  a_req_valid: assert property (@(posedge clk) disable iff (!rst_n)
    req_ready |-> req_v == cmd_take)
    else value_error("request valid does not follow the accepted command");
  a_req_route: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_take |-> req_v && req_x == exp_x && req_y == exp_y && req_addr == exp_epa)
    else value_error("request coordinates or network address do not match the decode");
  a_req_op: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_take |-> req_op == exp_op)
    else value_error("wrong network op");
  a_req_store: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_take && cmd_type != e_cmd_read |-> req_mask == exp_mask && req_data == cmd_data)
    else value_error("wrong byte mask or store data");
  a_req_info: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_take && cmd_type == e_cmd_read |-> req_info == exp_info)
    else value_error("wrong load info");
  a_req_id: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_take |-> req_reg_id == wr_idx[`BR_ID_W-1:0])
    else value_error("reg id out of allocation order");
  a_full_stall: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight == 6'd4 |-> !cmd_ready)
    else value_error("command accepted with all slots busy");
  a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight == 6'd0 |-> !resp_v)
    else value_error("response with nothing outstanding");
  a_resp_hdr: assert property (@(posedge clk) disable iff (!rst_n)
    resp_take |-> resp_type == exp_type[rd_idx] && resp_size == exp_size[rd_idx]
      && resp_addr == exp_addr[rd_idx])
    else value_error("response header out of command order");
  a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
    resp_take |-> resp_data == exp_data[rd_idx])
    else value_error("wrong response data");
  a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    resp_v && !resp_ready |=> resp_v && $stable(resp_type) && $stable(resp_size)
      && $stable(resp_addr) && $stable(resp_data))
    else value_error("held response changed");

  task automatic halt_with_fail();
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic value_error(string what);
    $display("ERROR %0d ns: %s", $time, what);
    halt_with_fail();
  endtask

  task automatic wait_expired(string what);
    $display("gave up waiting for %s", what);
    halt_with_fail();
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  function automatic logic [31:0] tile_addr(logic [3:0] y, logic [5:0] x,
                                            logic [17:0] epa, logic [1:0] low);
    return {`BR_TGT_TILE, y, x, epa, low};
  endfunction

  function automatic logic [31:0] vcache_addr(logic [1:0] pod, logic [5:0] x,
                                              logic [17:0] epa, logic [1:0] low);
    return {`BR_TGT_VCACHE, 2'b00, pod, x, epa, low};
  endfunction

  task automatic present_cmd(cmd_type_e t, amo_op_e a, msg_size_e s,
                             logic [31:0] addr, logic [31:0] data);
    @(negedge clk);
    cmd_type = t;
    cmd_amo  = a;
    cmd_size = s;
    cmd_addr = addr;
    cmd_data = data;
    cmd_v    = 1'b1;
  endtask

  task automatic wait_cmd_taken();
    int waited;
    waited = 0;
    while (!cmd_ready)
      begin
        if (waited == WAIT_LIMIT)
          wait_expired("the bridge to accept a command");
        waited++;
        @(negedge clk);
      end
    @(negedge clk);
    cmd_v = 1'b0;
  endtask

  task automatic send_cmd(cmd_type_e t, amo_op_e a, msg_size_e s,
                          logic [31:0] addr, logic [31:0] data);
    present_cmd(t, a, s, addr, data);
    wait_cmd_taken();
  endtask

  task automatic wait_resp_valid();
    int waited;
    waited = 0;
    while (!resp_v)
      begin
        if (waited == WAIT_LIMIT)
          wait_expired("a response to become valid");
        waited++;
        @(negedge clk);
      end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (in_flight != 6'd0)
      begin
        if (waited == WAIT_LIMIT)
          wait_expired("all outstanding responses");
        waited++;
        @(negedge clk);
      end
  endtask

  initial
    begin
      rst_n      = 1'b0;
      cmd_v      = 1'b0;
      cmd_type   = e_cmd_read;
      cmd_amo    = e_amo_add;
      cmd_size   = e_size_4;
      cmd_addr   = '0;
      cmd_data   = '0;
      req_ready  = 1'b0;
      resp_ready = 1'b1;
      my_x       = 6'd0;
      my_y       = 4'd8;
      repeat (2) @(negedge clk);
      rst_n     = 1'b1;
      req_ready = 1'b1;

      // tile reads
      send_cmd(e_cmd_read, e_amo_add, e_size_4, tile_addr(4'd3, 6'd5, 18'h01234, 2'd0), '0);
      send_cmd(e_cmd_read, e_amo_add, e_size_1, tile_addr(4'd2, 6'd7, 18'h00456, 2'd3), '0);
      wait_drained();

      // vcache writes on an odd pod and on pod zero
      send_cmd(e_cmd_write, e_amo_add, e_size_2, vcache_addr(2'd1, 6'd9, 18'h00abc, 2'd2),
               32'h1111_2222);
      send_cmd(e_cmd_write, e_amo_add, e_size_1, vcache_addr(2'd0, 6'd4, 18'h00010, 2'd1),
               32'h0000_00ab);
      wait_drained();

      // host link and the atomic subops
      send_cmd(e_cmd_read, e_amo_add, e_size_4, 32'h0001_2344, '0);
      send_cmd(e_cmd_atomic, e_amo_add, e_size_4, tile_addr(4'd1, 6'd2, 18'h00100, 2'd0), 32'd5);
      send_cmd(e_cmd_atomic, e_amo_or, e_size_4, tile_addr(4'd1, 6'd2, 18'h00104, 2'd0), 32'h30);
      send_cmd(e_cmd_atomic, e_amo_swap, e_size_4, tile_addr(4'd1, 6'd3, 18'h00108, 2'd0),
               32'hdead_beef);
      wait_drained();

      // mixed sizes whose returns reorder
      send_cmd(e_cmd_read, e_amo_add, e_size_1, tile_addr(4'd5, 6'd1, 18'h2a5a5, 2'd1), '0);
      send_cmd(e_cmd_read, e_amo_add, e_size_2, vcache_addr(2'd2, 6'd3, 18'h13579, 2'd2), '0);
      send_cmd(e_cmd_read, e_amo_add, e_size_4, tile_addr(4'd6, 6'd12, 18'h3c3c3, 2'd0), '0);
      send_cmd(e_cmd_read, e_amo_add, e_size_1, 32'h0002_f00d, '0);
      wait_drained();

      // host stalls responses until all slots fill
      @(negedge clk);
      resp_ready = 1'b0;
      send_cmd(e_cmd_read, e_amo_add, e_size_4, tile_addr(4'd4, 6'd6, 18'h00200, 2'd0), '0);
      send_cmd(e_cmd_write, e_amo_add, e_size_4, tile_addr(4'd4, 6'd7, 18'h00204, 2'd0), 32'h77);
      send_cmd(e_cmd_read, e_amo_add, e_size_2, tile_addr(4'd5, 6'd6, 18'h00208, 2'd0), '0);
      send_cmd(e_cmd_read, e_amo_add, e_size_1, tile_addr(4'd5, 6'd7, 18'h0020c, 2'd2), '0);
      present_cmd(e_cmd_read, e_amo_add, e_size_4, tile_addr(4'd2, 6'd2, 18'h00300, 2'd0), '0);
      wait_resp_valid();
      repeat (8) @(negedge clk);
      resp_ready = 1'b1;
      wait_cmd_taken();
      wait_drained();

      $display(">>> PASS");
      $finish;
    end

endmodule

/* list.f */
+incdir+source
source/bridge_pkg.sv
source/slot_bus_if.sv
source/cmd_translator.sv
source/txn_slot.sv
source/resp_drain.sv
source/mc_bridge_top.sv
verif/mc_net_model.sv
verif/tb_mc_bridge.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then scan the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mc_bridge \
  -f list.f -o tb_mc_bridge_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_mc_bridge_sim > sim.log 2>&1
grep -q '^>>> FAIL' sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q '^>>> PASS' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
